// ==== common/muldiv_settings.svh ====
//////////////////////////////////////////////////
// build settings of the RV32M multiply/divide unit
// MD_DIV_LATENCY must equal the number of set bits in MD_DIV_STAGE_MASK
// MD_LATENCY must leave at least one delay register after the multiplier
//////////////////////////////////////////////////

`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// operand and result width
`define MD_XLEN 32

// bit i set puts a register after divider row i, here every fourth row
`define MD_DIV_STAGE_MASK 32'h8888_8888
`define MD_DIV_LATENCY 8

// product registers behind the multiplier input register
`define MD_MUL_STAGES 3

// issue to result, input register plus array plus output register
`define MD_LATENCY (`MD_DIV_LATENCY + 2)

`define MD_TAG_W 5

`endif

// ==== common/muldiv_pkg.sv ====
//////////////////////////////////////////////////
// types shared by the multiply/divide unit
// opcode encoding follows the RV32M funct3 field
//////////////////////////////////////////////////

`include "muldiv_settings.svh"

package muldiv_pkg;

	// the value of each operation is its funct3 code
	typedef enum logic [2:0] {
		op_mul    = 3'd0,
		op_mulh   = 3'd1,
		op_mulhsu = 3'd2,
		op_mulhu  = 3'd3,
		op_div    = 3'd4,
		op_divu   = 3'd5,
		op_rem    = 3'd6,
		op_remu   = 3'd7
	} md_op_e;

	// request from the core, 72 bits
	typedef struct packed {
		md_op_e                 op;
		logic [`MD_XLEN-1:0]    a;
		logic [`MD_XLEN-1:0]    b;
		logic [`MD_TAG_W-1:0]   tag;
	} md_req_t;

	// result back to the core, 37 bits
	typedef struct packed {
		logic [`MD_XLEN-1:0]    result;
		logic [`MD_TAG_W-1:0]   tag;
	} md_rsp_t;

	// what the sign restore needs at the far end of the divide array, 9 bits
	typedef struct packed {
		logic                   neg_quo;
		logic                   neg_rem;
		logic                   div_zero;
		logic                   sel_rem;
		logic [`MD_TAG_W-1:0]   tag;
	} md_div_side_t;

endpackage

// ==== divider/div_array.sv ====
//////////////////////////////////////////////////
// unsigned restoring divider, one quotient bit per row
// registered rows come from MD_DIV_STAGE_MASK, the rest is combinational
// a zero divisor gives all ones and the dividend as remainder
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "muldiv_settings.svh"

module div_array import muldiv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_valid,
	input  logic [`MD_XLEN-1:0]   i_dividend,
	input  logic [`MD_XLEN-1:0]   i_divisor,
	input  md_div_side_t          i_side,
	output logic                  o_valid,
	output logic [`MD_XLEN-1:0]   o_quotient,
	output logic [`MD_XLEN-1:0]   o_remainder,
	output md_div_side_t          o_side
);

	localparam int XLEN = `MD_XLEN;
	localparam logic [XLEN-1:0] STAGE_MASK = `MD_DIV_STAGE_MASK;

	// the whole state of one division between two rows
	typedef struct packed {
		logic [XLEN-1:0] rem;
		logic [XLEN-1:0] dvd;
		logic [XLEN-1:0] quo;
		logic [XLEN-1:0] dsr;
		md_div_side_t    side;
	} row_t;

	// element i feeds row i, element XLEN is the array output
	logic row_vld [0:XLEN];
	row_t row     [0:XLEN];

	// the stage mask and the latency setting must agree or the unit loses order
	if ($countones(STAGE_MASK) != `MD_DIV_LATENCY) begin : g_mask_check
		$error("divider stage mask does not match MD_DIV_LATENCY");
	end

	assign row_vld[0] = i_valid;
	assign row[0] = '{rem: '0, dvd: i_dividend, quo: '0, dsr: i_divisor, side: i_side};

	//////////////////////////////////////////////////
	// rows
	//////////////////////////////////////////////////

	for (genvar i = 0; i < XLEN; i++) begin : g_row
		logic [XLEN:0] trial;
		logic [XLEN:0] diff;
		logic          q_bit;
		row_t          nxt;

		// bring down the next dividend bit, msb first
		assign trial = {row[i].rem, row[i].dvd[XLEN-1]};
		// the partial remainder stays below the divisor so the top bit of diff is the borrow
		assign diff  = trial - {1'b0, row[i].dsr};
		assign q_bit = ~diff[XLEN];

		always_comb begin
			nxt     = row[i];
			nxt.rem = q_bit ? diff[XLEN-1:0] : trial[XLEN-1:0];
			nxt.dvd = {row[i].dvd[XLEN-2:0], 1'b0};
			nxt.quo = {row[i].quo[XLEN-2:0], q_bit};
		end

		if (STAGE_MASK[i]) begin : g_reg
			logic vld_q;
			row_t row_q;

			// only the valid bit is reset, so several divisions can share the array
			always_ff @(posedge clk) begin
				if (rst) begin
					vld_q <= 1'b0;
				end else begin
					vld_q <= row_vld[i];
				end
			end

			always_ff @(posedge clk) begin
				row_q <= nxt;
			end

			assign row_vld[i+1] = vld_q;
			assign row[i+1]     = row_q;
		end else begin : g_comb
			assign row_vld[i+1] = row_vld[i];
			assign row[i+1]     = nxt;
		end
	end

	assign o_valid     = row_vld[XLEN];
	assign o_quotient  = row[XLEN].quo;
	assign o_remainder = row[XLEN].rem;
	assign o_side      = row[XLEN].side;

endmodule

// ==== divider/div_signed.sv ====
//////////////////////////////////////////////////
// signed and unsigned divide and remainder around the unsigned array
// latency is MD_DIV_LATENCY plus an input and an output register
// divide by zero and signed overflow follow the RV32M rules
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "muldiv_settings.svh"

module div_signed import muldiv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_valid,
	input  md_req_t i_req,
	output logic    o_valid,
	output md_rsp_t o_rsp
);

	localparam int XLEN = `MD_XLEN;

	logic               is_signed;
	logic               sign_a;
	logic               sign_b;
	logic [XLEN-1:0]    mag_a;
	logic [XLEN-1:0]    mag_b;
	md_div_side_t       side_d;

	logic               in_vld;
	logic [XLEN-1:0]    in_a;
	logic [XLEN-1:0]    in_b;
	md_div_side_t       in_side;

	logic               arr_vld;
	logic [XLEN-1:0]    arr_quo;
	logic [XLEN-1:0]    arr_rem;
	md_div_side_t       arr_side;

	logic [XLEN-1:0]    quo_fix;
	logic [XLEN-1:0]    rem_fix;

	//////////////////////////////////////////////////
	// magnitudes and sideband
	//////////////////////////////////////////////////

	always_comb begin
		is_signed = (i_req.op == op_div) || (i_req.op == op_rem);
		sign_a    = is_signed & i_req.a[XLEN-1];
		sign_b    = is_signed & i_req.b[XLEN-1];
		// the minimum value maps onto itself, which is its correct magnitude as unsigned
		mag_a     = sign_a ? -i_req.a : i_req.a;
		mag_b     = sign_b ? -i_req.b : i_req.b;

		side_d.neg_quo  = sign_a ^ sign_b;
		// the remainder takes the sign of the dividend
		side_d.neg_rem  = sign_a;
		side_d.div_zero = (i_req.b == '0);
		side_d.sel_rem  = (i_req.op == op_rem) || (i_req.op == op_remu);
		side_d.tag      = i_req.tag;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			in_vld <= 1'b0;
		end else begin
			in_vld <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		in_a    <= mag_a;
		in_b    <= mag_b;
		in_side <= side_d;
	end

	div_array u_array (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (in_vld),
		.i_dividend  (in_a),
		.i_divisor   (in_b),
		.i_side      (in_side),
		.o_valid     (arr_vld),
		.o_quotient  (arr_quo),
		.o_remainder (arr_rem),
		.o_side      (arr_side)
	);

	//////////////////////////////////////////////////
	// sign restore
	//////////////////////////////////////////////////

	// the array already gives all ones for a zero divisor, so that quotient keeps its sign
	// the negated remainder magnitude is the original dividend again in that case
	always_comb begin
		quo_fix = (arr_side.neg_quo && !arr_side.div_zero) ? -arr_quo : arr_quo;
		rem_fix = arr_side.neg_rem ? -arr_rem : arr_rem;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= arr_vld;
		end
	end

	always_ff @(posedge clk) begin
		o_rsp.result <= arr_side.sel_rem ? rem_fix : quo_fix;
		o_rsp.tag    <= arr_side.tag;
	end

endmodule

// ==== source/mul_pipe.sv ====
//////////////////////////////////////////////////
// RV32M multiplier for DSP blocks, 33x33 signed with extended operands
// product registers are meant to be retimed into the DSP pipeline
// a delay line pads the path to MD_LATENCY
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "muldiv_settings.svh"

module mul_pipe import muldiv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_valid,
	input  md_req_t i_req,
	output logic    o_valid,
	output md_rsp_t o_rsp
);

	localparam int XLEN   = `MD_XLEN;
	localparam int STAGES = `MD_MUL_STAGES;
	// whatever is left of the unit latency after the input and product registers
	localparam int DLY    = `MD_LATENCY - 1 - `MD_MUL_STAGES;

	typedef struct packed {
		logic                   hi;
		logic [`MD_TAG_W-1:0]   tag;
	} mul_side_t;

	logic                       a_sgn;
	logic                       b_sgn;
	mul_side_t                  side_d;

	logic                       in_vld;
	logic signed [XLEN:0]       in_a;
	logic signed [XLEN:0]       in_b;
	mul_side_t                  in_side;
	logic signed [2*XLEN+1:0]   prod;

	logic [STAGES-1:0]          st_vld;
	logic [2*XLEN-1:0]          st_prod [STAGES];
	mul_side_t                  st_side [STAGES];

	md_rsp_t                    sel_rsp;
	logic [DLY-1:0]             dly_vld;
	md_rsp_t                    dly_rsp [DLY];

	// mulhu zero extends both, mulhsu only b, mul takes the low word so either works
	always_comb begin
		a_sgn      = (i_req.op != op_mulhu);
		b_sgn      = (i_req.op == op_mul) || (i_req.op == op_mulh);
		side_d.hi  = (i_req.op != op_mul);
		side_d.tag = i_req.tag;
	end

	always_ff @(posedge clk) begin
		in_a    <= {a_sgn & i_req.a[XLEN-1], i_req.a};
		in_b    <= {b_sgn & i_req.b[XLEN-1], i_req.b};
		in_side <= side_d;
	end

	assign prod = in_a * in_b;

	//////////////////////////////////////////////////
	// product pipeline and delay line
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			in_vld  <= 1'b0;
			st_vld  <= '0;
			dly_vld <= '0;
		end else begin
			in_vld     <= i_valid;
			st_vld[0]  <= in_vld;
			for (int k = 1; k < STAGES; k++) begin
				st_vld[k] <= st_vld[k-1];
			end
			dly_vld[0] <= st_vld[STAGES-1];
			for (int k = 1; k < DLY; k++) begin
				dly_vld[k] <= dly_vld[k-1];
			end
		end
	end

	// the low 64 bits of the 66 bit product are the full 32x32 result
	always_ff @(posedge clk) begin
		st_prod[0] <= prod[2*XLEN-1:0];
		st_side[0] <= in_side;
		for (int k = 1; k < STAGES; k++) begin
			st_prod[k] <= st_prod[k-1];
			st_side[k] <= st_side[k-1];
		end
		dly_rsp[0] <= sel_rsp;
		for (int k = 1; k < DLY; k++) begin
			dly_rsp[k] <= dly_rsp[k-1];
		end
	end

	always_comb begin
		sel_rsp.result = st_side[STAGES-1].hi ? st_prod[STAGES-1][2*XLEN-1:XLEN]
		                                      : st_prod[STAGES-1][XLEN-1:0];
		sel_rsp.tag    = st_side[STAGES-1].tag;
	end

	assign o_valid = dly_vld[DLY-1];
	assign o_rsp   = dly_rsp[DLY-1];

endmodule

// ==== source/muldiv_unit.sv ====
//////////////////////////////////////////////////
// RV32M multiply/divide unit, one request per cycle, no back-pressure
// every result leaves MD_LATENCY cycles after issue, in issue order
// the consumer must take each result in its valid cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module muldiv_unit import muldiv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_valid,
	input  md_req_t i_req,
	output logic    o_valid,
	output md_rsp_t o_rsp
);

	logic       is_div;
	logic       div_issue;
	logic       mul_issue;

	logic       div_vld;
	md_rsp_t    div_rsp;
	logic       mul_vld;
	md_rsp_t    mul_rsp;

	//////////////////////////////////////////////////
	// issue
	//////////////////////////////////////////////////

	// each request goes to exactly one path
	always_comb begin
		is_div    = i_req.op inside {op_div, op_divu, op_rem, op_remu};
		div_issue = i_valid & is_div;
		mul_issue = i_valid & ~is_div;
	end

	div_signed u_div (
		.clk     (clk),
		.rst     (rst),
		.i_valid (div_issue),
		.i_req   (i_req),
		.o_valid (div_vld),
		.o_rsp   (div_rsp)
	);

	mul_pipe u_mul (
		.clk     (clk),
		.rst     (rst),
		.i_valid (mul_issue),
		.i_req   (i_req),
		.o_valid (mul_vld),
		.o_rsp   (mul_rsp)
	);

	//////////////////////////////////////////////////
	// completion
	//////////////////////////////////////////////////

	// both paths have the same latency, so at most one of them completes per cycle
	always_comb begin
		o_valid = div_vld | mul_vld;
		o_rsp   = div_vld ? div_rsp : mul_rsp;
	end

endmodule

// ==== dv/muldiv_assert.sv ====
//////////////////////////////////////////////////
// protocol checks bound into muldiv_unit
// every issue completes exactly MD_LATENCY cycles later
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "muldiv_settings.svh"

module muldiv_assert (
	input logic clk,
	input logic rst,
	input logic i_valid,
	input logic o_valid
);

	localparam int LAT = `MD_LATENCY;

	// the valid registers clear on the reset edge
	a_quiet_in_reset: assert property (@(posedge clk) rst |=> !o_valid)
		else $error("o_valid high while reset is applied");

	// no back-pressure, so nothing can hold a result back
	a_fixed_latency: assert property (
		@(posedge clk) disable iff (rst) i_valid |-> ##LAT o_valid
	) else $error("accepted request did not complete after MD_LATENCY cycles");

	// a result always traces back to an issue
	a_no_orphan: assert property (
		@(posedge clk) disable iff (rst) o_valid |-> $past(i_valid, LAT)
	) else $error("o_valid without a matching issue");

endmodule

bind muldiv_unit muldiv_assert u_assert (
	.clk     (clk),
	.rst     (rst),
	.i_valid (i_valid),
	.o_valid (o_valid)
);

// ==== dv/muldiv_tb.sv ====
//////////////////////////////////////////////////
// testbench for the RV32M multiply/divide unit
// directed vectors come from dv/muldiv_stimulus.txt, so run it from the project root
// the random phase uses a fixed xorshift seed and repeats exactly on every run
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "muldiv_settings.svh"

module muldiv_tb import muldiv_pkg::*; ();

	localparam int LAT     = `MD_LATENCY;
	localparam int N_RAND  = 300;
	localparam int MAX_VEC = 64;

	logic                   clk;
	logic                   rst;
	logic                   i_valid;
	md_req_t                i_req;
	logic                   o_valid;
	md_rsp_t                o_rsp;

	// four words per vector: opcode, operand a, operand b, expected result
	logic [31:0]            vec_mem [0:4*MAX_VEC-1];
	int                     n_vec;

	// expected responses and the edge at which each request was taken, in issue order
	md_rsp_t                exp_q [$];
	int                     issue_q [$];

	int                     cycle = 0;
	int                     limit;
	logic [31:0]            rng;
	logic [`MD_TAG_W-1:0]   next_tag;

	muldiv_unit u_dut (
		.clk     (clk),
		.rst     (rst),
		.i_valid (i_valid),
		.i_req   (i_req),
		.o_valid (o_valid),
		.o_rsp   (o_rsp)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// RV32M rules worked out on 64 bit values
	function automatic logic [31:0] rv32m_result(input md_op_e op, input logic [31:0] a,
	                                             input logic [31:0] b);
		logic signed [63:0] a_s;
		logic signed [63:0] b_s;
		logic signed [63:0] b_z;
		logic signed [63:0] p_ss;
		logic signed [63:0] p_su;
		logic [63:0]        p_uu;
		logic signed [63:0] q_s;
		logic signed [63:0] r_s;
		logic [31:0]        q_u;
		logic [31:0]        r_u;
		logic [31:0]        r;
		a_s  = {{32{a[31]}}, a};
		b_s  = {{32{b[31]}}, b};
		b_z  = {32'h0, b};
		p_ss = a_s * b_s;
		p_su = a_s * b_z;
		p_uu = {32'h0, a} * {32'h0, b};
		// at 64 bits the minimum value over minus one does not overflow,
		// its low word is the RV32M answer with a zero remainder
		if (b != '0) begin
			q_s = a_s / b_s;
			r_s = a_s % b_s;
			q_u = a / b;
			r_u = a % b;
		end
		case (op)
			op_mul:    r = p_ss[31:0];
			op_mulh:   r = p_ss[63:32];
			op_mulhsu: r = p_su[63:32];
			op_mulhu:  r = p_uu[63:32];
			op_div:    r = (b == '0) ? '1 : q_s[31:0];
			op_divu:   r = (b == '0) ? '1 : q_u;
			op_rem:    r = (b == '0) ? a : r_s[31:0];
			default:   r = (b == '0) ? a : r_u;
		endcase
		return r;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic issue_req(input md_op_e op, input logic [31:0] a, input logic [31:0] b,
	                         input logic [31:0] exp);
		@(negedge clk);
		i_valid = 1'b1;
		i_req   = '{op: op, a: a, b: b, tag: next_tag};
		exp_q.push_back('{result: exp, tag: next_tag});
		// the request is taken at the coming rising edge
		issue_q.push_back(cycle + 1);
		next_tag = next_tag + 1'b1;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		i_valid = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic run_directed();
		md_op_e      op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp;
		// back to back, one request per cycle
		for (int k = 0; k < n_vec; k++) begin
			op  = md_op_e'(vec_mem[4*k][2:0]);
			a   = vec_mem[4*k+1];
			b   = vec_mem[4*k+2];
			exp = vec_mem[4*k+3];
			check_value($sformatf("reference model on vector %0d", k),
			            rv32m_result(op, a, b), exp);
			issue_req(op, a, b, exp);
		end
	endtask

	task automatic run_random();
		md_op_e      op;
		logic [31:0] a;
		logic [31:0] b;
		for (int k = 0; k < N_RAND; k++) begin
			rng = xorshift32(rng);
			op  = md_op_e'(rng[2:0]);
			rng = xorshift32(rng);
			a   = rng;
			rng = xorshift32(rng);
			b   = rng;
			// a short divisor gives long quotients
			if (rng[9:8] == 2'b00) begin
				b = b >> 24;
			end
			// zero and minimum value operands come round every 16 requests
			case (k % 16)
				3: b = '0;
				7: a = 32'h8000_0000;
				11: begin
					a = 32'h8000_0000;
					b = 32'hffff_ffff;
				end
				14: begin
					a = 32'h8000_0000;
					b = 32'h8000_0000;
				end
				default: ;
			endcase
			issue_req(op, a, b, rv32m_result(op, a, b));
			if (rng[31:30] == 2'b00) begin
				idle_cycle();
			end
		end
	endtask

	//////////////////////////////////////////////////
	// checking and timeout
	//////////////////////////////////////////////////

	// outputs are registered, so the values seen at a rising edge are those of the cycle before
	always @(posedge clk) begin : monitor
		md_rsp_t exp_rsp;
		int      issued;
		if (rst) begin
			// from the second reset edge on, the valid registers have been cleared
			if (cycle > 0 && o_valid !== 1'b0) begin
				abort_run("o_valid was not low while reset was applied");
			end
		end else if ($isunknown(o_valid)) begin
			abort_run("o_valid is unknown after reset");
		end else if (o_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("o_valid was raised with no request outstanding");
			end else begin
				exp_rsp = exp_q.pop_front();
				issued  = issue_q.pop_front();
				check_value("response tag", o_rsp.tag, exp_rsp.tag);
				check_value($sformatf("result for tag %0d", exp_rsp.tag), o_rsp.result,
				            exp_rsp.result);
				// this edge is number cycle + 1 and must lie LAT edges after the issue edge
				check_value("issue to result latency", cycle + 1 - issued, LAT);
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > limit) begin
			abort_run($sformatf("timeout: the run was still going after %0d cycles", cycle));
		end
	end

	initial begin
		clk      = 1'b0;
		rst      = 1'b1;
		i_valid  = 1'b0;
		i_req    = '0;
		next_tag = '0;
		rng      = 32'h49a1;
		$readmemh("dv/muldiv_stimulus.txt", vec_mem);
		n_vec = 0;
		while (n_vec < MAX_VEC && !$isunknown(vec_mem[4*n_vec])) begin
			n_vec++;
		end
		// each request takes at most two cycles, then the pipe drains
		limit = (n_vec + N_RAND) * 2 + LAT + 50;
		if (n_vec == 0) begin
			abort_run("no vectors could be read from dv/muldiv_stimulus.txt");
		end else begin
			repeat (2) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			// a few quiet cycles, o_valid must stay low before the first request
			repeat (4) idle_cycle();
			run_directed();
			run_random();
			idle_cycle();
			repeat (LAT + 5) idle_cycle();
			if (exp_q.size() == 0) begin
				$display("TEST OK");
				$finish;
			end else begin
				abort_run($sformatf("%0d results never came back", exp_q.size()));
			end
		end
	end

endmodule

// ==== dv/muldiv_stimulus.txt ====
// columns: opcode (0 mul .. 7 remu, the funct3 code), operand a, operand b, expected result
// all values in hexadecimal, one request per line
0 00000003 00000007 00000015
0 ffffffff ffffffff 00000001
0 80000000 80000000 00000000
0 0000ffff 0000ffff fffe0001
1 80000000 80000000 40000000
1 ffffffff ffffffff 00000000
1 ffffffff 00000002 ffffffff
1 7fffffff 7fffffff 3fffffff
2 ffffffff ffffffff ffffffff
2 80000000 80000000 c0000000
2 00000002 ffffffff 00000001
3 ffffffff ffffffff fffffffe
3 80000000 80000000 40000000
3 00000003 00000007 00000000
4 00000014 00000006 00000003
4 ffffffec 00000006 fffffffd
4 00000014 fffffffa fffffffd
4 ffffffec fffffffa 00000003
4 80000000 ffffffff 80000000
4 00000014 00000000 ffffffff
4 ffffffec 00000000 ffffffff
5 ffffffec 00000006 2aaaaaa7
5 00000014 00000000 ffffffff
5 80000000 ffffffff 00000000
6 00000014 00000006 00000002
6 ffffffec 00000006 fffffffe
6 00000014 fffffffa 00000002
6 ffffffec fffffffa fffffffe
6 80000000 ffffffff 00000000
6 ffffffec 00000000 ffffffec
7 ffffffec 00000006 00000002
7 00000014 00000000 00000014
7 80000000 ffffffff 80000000

// ==== vlog.f ====
+incdir+common
common/muldiv_pkg.sv
divider/div_array.sv
divider/div_signed.sv
source/mul_pipe.sv
source/muldiv_unit.sv
dv/muldiv_assert.sv
dv/muldiv_tb.sv
